//--- files.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_imm_gen.sv
verilog/exu_branch_unit.sv
verilog/exu_ctrl.sv
verilog/exu_top.sv
sim/exu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

OUT="$(verilator --binary --timing --top-module exu_tb -f files.f -o exu_sim 2>&1 \
	&& ./obj_dir/exu_sim 2>&1)"
echo "$OUT"

echo "$OUT" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

//--- sim/exu_tb.sv
// Execute stage testbench with LFSR stimulus, reference model, back-pressure and result checking
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

	import exu_pkg::*;

	localparam int N_OP    = 40;
	localparam int N_IMM   = 40;
	localparam int N_BR    = 36;
	localparam int N_UPPER = 24;
	localparam int N_BP    = 60;
	localparam int N_TOTAL = N_OP + N_IMM + N_BR + N_UPPER + N_BP;
	// Two cycles per transaction worst case plus reset and drain slack
	localparam int CYCLE_LIMIT = 2 * N_TOTAL + 100;

	logic                 clk       = 1'b0;
	logic                 reset     = 1'b1;
	logic                 in_valid  = 1'b0;
	logic                 in_ready;
	inst_u                inst      = '0;
	logic [`EXU_XLEN-1:0] pc        = '0;
	logic [`EXU_XLEN-1:0] rs1_data  = '0;
	logic [`EXU_XLEN-1:0] rs2_data  = '0;
	logic                 out_valid;
	logic                 out_ready = 1'b0;
	logic [4:0]           rd_addr;
	logic [`EXU_XLEN-1:0] rd_data;
	logic                 rd_write;
	logic [`EXU_XLEN-1:0] next_pc;
	logic                 branch_taken;
	logic                 illegal;

	logic [31:0] lfsr = 32'd8;
	logic        bp_on = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          results = 0;
	int          cycles = 0;

	// Expected results with one entry per accepted instruction
	logic [4:0]           q_rd[$];
	logic [`EXU_XLEN-1:0] q_data[$];
	logic                 q_write[$];
	logic [`EXU_XLEN-1:0] q_npc[$];
	logic                 q_taken[$];
	logic                 q_ill[$];

	// Output snapshot while stalled
	logic                 hold_valid = 1'b0;
	logic                 accepted_last = 1'b0;
	logic [4:0]           held_rd;
	logic [`EXU_XLEN-1:0] held_data;
	logic                 held_write;
	logic [`EXU_XLEN-1:0] held_npc;
	logic                 held_taken;
	logic                 held_ill;

	// Pre-generated back-pressure traffic
	inst_u                bp_inst [N_BP];
	logic [`EXU_XLEN-1:0] bp_pc [N_BP];
	logic [`EXU_XLEN-1:0] bp_a [N_BP];
	logic [`EXU_XLEN-1:0] bp_b [N_BP];

	logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	// Opcodes outside the supported groups
	logic [6:0] bad_opc [8] = '{7'b0000011, 7'b0100011, 7'b1101111, 7'b1100111,
		7'b1110011, 7'b0001111, 7'b0000000, 7'b1111111};

	exu_top exu_top_inst (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.inst         (inst),
		.pc           (pc),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.rd_write     (rd_write),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

	always #10 clk = ~clk;

	// Galois LFSR stepped once per output bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          j;
		val = '0;
		for (j = 0; j < n; j++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic check_word(input string name, input logic [`EXU_XLEN-1:0] got,
		input logic [`EXU_XLEN-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, want);
		end
	endtask

	// Expected stage outputs straight from the RV32I rules
	function automatic void ref_model(input inst_u w, input logic [31:0] p, a, b,
		output logic [4:0] e_rd, output logic [31:0] e_data, output logic e_write,
		output logic [31:0] e_npc, output logic e_taken, output logic e_ill);
		logic [31:0] x;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] opb;
		logic [2:0]  f3;
		logic        alt;
		logic        cond;
		x       = w;
		f3      = x[14:12];
		imm_i   = {{20{x[31]}}, x[31:20]};
		imm_b   = {{19{x[31]}}, x[31], x[7], x[30:25], x[11:8], 1'b0};
		imm_u   = {x[31:12], 12'b0};
		e_rd    = x[11:7];
		e_data  = '0;
		e_write = 1'b0;
		e_npc   = p + 32'd4;
		e_taken = 1'b0;
		e_ill   = 1'b0;
		case (x[6:0])
			`OPC_OP, `OPC_OP_IMM: begin
				opb = (x[6:0] == `OPC_OP) ? b : imm_i;
				// Bit 30 picks sub only for register ops and sra for both
				alt = x[30] && (x[6:0] == `OPC_OP || f3 == 3'b101);
				case (f3)
					3'd0: e_data = alt ? a - opb : a + opb;
					3'd1: e_data = a << opb[4:0];
					3'd2: e_data = {31'b0, $signed(a) < $signed(opb)};
					3'd3: e_data = {31'b0, a < opb};
					3'd4: e_data = a ^ opb;
					3'd5: e_data = alt ? $unsigned($signed(a) >>> opb[4:0]) : a >> opb[4:0];
					3'd6: e_data = a | opb;
					3'd7: e_data = a & opb;
				endcase
				e_write = (e_rd != 5'd0);
			end
			`OPC_BRANCH: begin
				case (f3)
					3'd0:    cond = (a == b);
					3'd1:    cond = (a != b);
					3'd4:    cond = ($signed(a) < $signed(b));
					3'd5:    cond = ($signed(a) >= $signed(b));
					3'd6:    cond = (a < b);
					3'd7:    cond = (a >= b);
					default: cond = 1'b0;
				endcase
				e_taken = cond;
				if (cond) begin
					e_npc = p + imm_b;
				end
			end
			`OPC_LUI: begin
				e_data  = imm_u;
				e_write = (e_rd != 5'd0);
			end
			`OPC_AUIPC: begin
				e_data  = p + imm_u;
				e_write = (e_rd != 5'd0);
			end
			default: e_ill = 1'b1;
		endcase
	endfunction

	// Register op where k walks funct3 and picks sub/sra on alternate rounds
	function automatic void gen_op(input int k, output inst_u w, output logic [31:0] a, b);
		logic [2:0] f3;
		f3 = k[2:0];
		w.r.funct7 = {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? k[3] : 1'b0, 5'b0};
		w.r.rs2    = 5'(rand_bits(5));
		w.r.rs1    = 5'(rand_bits(5));
		w.r.funct3 = f3;
		w.r.rd     = (k % 10 == 0) ? 5'd0 : 5'(rand_bits(5));
		w.r.opcode = `OPC_OP;
		a = rand_bits(32);
		b = rand_bits(32);
	endfunction

	function automatic void gen_imm(input int k, output inst_u w, output logic [31:0] a, b);
		logic [2:0]  f3;
		logic [11:0] imm;
		f3 = k[2:0];
		case (f3)
			3'd1:    imm = {7'b0, 5'(rand_bits(5))};
			3'd5:    imm = {1'b0, k[3], 5'b0, 5'(rand_bits(5))};
			// Every other round forced negative
			default: imm = 12'(rand_bits(12)) | {k[3], 11'b0};
		endcase
		w.i.imm12  = imm;
		w.i.rs1    = 5'(rand_bits(5));
		w.i.funct3 = f3;
		w.i.rd     = 5'(rand_bits(5));
		w.i.opcode = `OPC_OP_IMM;
		a = rand_bits(32);
		b = rand_bits(32);
	endfunction

	// Six conditions against six operand pairings
	function automatic void gen_branch(input int k, output inst_u w, output logic [31:0] a, b);
		logic [12:0] off;
		case ((k / 6) % 6)
			0: begin
				a = rand_bits(32);
				b = a;
			end
			1: begin
				a = {2'b00, 30'(rand_bits(30))};
				b = a + rand_bits(8) + 32'd1;
			end
			2: begin
				b = {2'b00, 30'(rand_bits(30))};
				a = b + rand_bits(8) + 32'd1;
			end
			// Negative against positive where signed and unsigned disagree
			3: begin
				a = {1'b1, 31'(rand_bits(31))};
				b = {1'b0, 31'(rand_bits(31))};
			end
			4: begin
				a = {1'b0, 31'(rand_bits(31))};
				b = {1'b1, 31'(rand_bits(31))};
			end
			default: begin
				a = {1'b1, 31'(rand_bits(31))};
				b = {1'b1, 31'(rand_bits(31))};
			end
		endcase
		off = {12'(rand_bits(12)), 1'b0};
		w.b.imm12   = off[12];
		w.b.imm10_5 = off[10:5];
		w.b.rs2     = 5'(rand_bits(5));
		w.b.rs1     = 5'(rand_bits(5));
		w.b.funct3  = br_f3[k % 6];
		w.b.imm4_1  = off[4:1];
		w.b.imm11   = off[11];
		w.b.opcode  = `OPC_BRANCH;
	endfunction

	// LUI, then AUIPC, then unsupported opcodes
	function automatic void gen_upper(input int k, output inst_u w, output logic [31:0] a, b);
		w.u.imm20 = 20'(rand_bits(20));
		w.u.rd    = (k % 8 == 0) ? 5'd0 : 5'(rand_bits(5));
		if (k < 8) begin
			w.u.opcode = `OPC_LUI;
		end else if (k < 16) begin
			w.u.opcode = `OPC_AUIPC;
		end else begin
			w.u.opcode = bad_opc[k % 8];
		end
		a = rand_bits(32);
		b = rand_bits(32);
	endfunction

	// Present one instruction and wait for its accept edge
	task automatic drive(input inst_u w, input logic [31:0] p, a, b);
		in_valid <= 1'b1;
		inst     <= w;
		pc       <= p;
		rs1_data <= a;
		rs2_data <= b;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic drain_and_report(input int num, input string name, input int base);
		in_valid <= 1'b0;
		@(negedge clk);
		while (q_rd.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
		$display("Test %0d %s: %0d errors", num, name, errors - base);
	endtask

	// out_ready low through reset and one cycle in four while stalling
	always @(posedge clk) begin
		if (reset) begin
			out_ready <= 1'b0;
		end else if (bp_on) begin
			out_ready <= (rand_bits(2) != 32'd3);
		end else begin
			out_ready <= 1'b1;
		end
	end

	// Accept tracking, output compare and stall stability
	always @(posedge clk) begin : monitor
		logic [4:0]  e_rd;
		logic [31:0] e_data;
		logic        e_write;
		logic [31:0] e_npc;
		logic        e_taken;
		logic        e_ill;
		if (reset) begin
			hold_valid    = 1'b0;
			accepted_last = 1'b0;
		end else begin
			if (accepted_last && !out_valid) begin
				errors++;
				$display("Output valid did not rise one cycle after an accept");
			end
			if (hold_valid) begin
				check_flag("out_valid held", out_valid, 1'b1);
				check_reg("rd_addr held", rd_addr, held_rd);
				check_word("rd_data held", rd_data, held_data);
				check_flag("rd_write held", rd_write, held_write);
				check_word("next_pc held", next_pc, held_npc);
				check_flag("branch_taken held", branch_taken, held_taken);
				check_flag("illegal held", illegal, held_ill);
			end
			if (out_valid && out_ready) begin
				if (q_rd.size() == 0) begin
					errors++;
					$display("Result delivered with no instruction outstanding");
				end else begin
					e_rd    = q_rd.pop_front();
					e_data  = q_data.pop_front();
					e_write = q_write.pop_front();
					e_npc   = q_npc.pop_front();
					e_taken = q_taken.pop_front();
					e_ill   = q_ill.pop_front();
					check_flag("rd_write", rd_write, e_write);
					// Address and data only matter when written
					if (e_write) begin
						check_reg("rd_addr", rd_addr, e_rd);
						check_word("rd_data", rd_data, e_data);
					end
					check_word("next_pc", next_pc, e_npc);
					check_flag("branch_taken", branch_taken, e_taken);
					check_flag("illegal", illegal, e_ill);
					results++;
				end
			end
			hold_valid    = out_valid && !out_ready;
			held_rd       = rd_addr;
			held_data     = rd_data;
			held_write    = rd_write;
			held_npc      = next_pc;
			held_taken    = branch_taken;
			held_ill      = illegal;
			accepted_last = in_valid && in_ready;
			if (accepted_last) begin
				ref_model(inst, pc, rs1_data, rs2_data, e_rd, e_data, e_write, e_npc,
					e_taken, e_ill);
				q_rd.push_back(e_rd);
				q_data.push_back(e_data);
				q_write.push_back(e_write);
				q_npc.push_back(e_npc);
				q_taken.push_back(e_taken);
				q_ill.push_back(e_ill);
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int         k;
		int         base;
		int         idx;
		logic [1:0] kind;
		inst_u      w;
		logic [31:0] a;
		logic [31:0] b;

		// Reset state
		base = errors;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("rd_write", rd_write, 1'b0);
		check_flag("branch_taken", branch_taken, 1'b0);
		check_flag("illegal", illegal, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
		@(posedge clk);
		$display("Test 6 reset: %0d errors", errors - base);

		base = errors;
		for (k = 0; k < N_OP; k++) begin
			gen_op(k, w, a, b);
			drive(w, rand_bits(30) << 2, a, b);
		end
		drain_and_report(1, "register ops", base);

		base = errors;
		for (k = 0; k < N_IMM; k++) begin
			gen_imm(k, w, a, b);
			drive(w, rand_bits(30) << 2, a, b);
		end
		drain_and_report(2, "immediate ops", base);

		base = errors;
		for (k = 0; k < N_BR; k++) begin
			gen_branch(k, w, a, b);
			drive(w, rand_bits(30) << 2, a, b);
		end
		drain_and_report(3, "branches", base);

		base = errors;
		for (k = 0; k < N_UPPER; k++) begin
			gen_upper(k, w, a, b);
			drive(w, rand_bits(30) << 2, a, b);
		end
		drain_and_report(4, "upper immediates and illegal", base);

		// Mixed traffic generated before the stalls start
		base = errors;
		for (k = 0; k < N_BP; k++) begin
			kind = 2'(rand_bits(2));
			idx  = rand_bits(6);
			case (kind)
				2'd0: gen_op(idx, w, a, b);
				2'd1: gen_imm(idx, w, a, b);
				2'd2: gen_branch(idx, w, a, b);
				2'd3: gen_upper(idx, w, a, b);
			endcase
			bp_inst[k] = w;
			bp_pc[k]   = rand_bits(30) << 2;
			bp_a[k]    = a;
			bp_b[k]    = b;
		end
		bp_on <= 1'b1;
		for (k = 0; k < N_BP; k++) begin
			drive(bp_inst[k], bp_pc[k], bp_a[k], bp_b[k]);
		end
		drain_and_report(5, "back-pressure", base);
		bp_on <= 1'b0;

		$display("Checks %0d, results %0d of %0d, errors %0d", checks, results, N_TOTAL, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/exu_alu.sv
// Integer ALU with add, subtract, logic, shifts and compares plus less and zero flags
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
	input  wire logic [`EXU_XLEN-1:0]     src1,
	input  wire logic [`EXU_XLEN-1:0]     src2,
	input  wire logic [`EXU_ALU_OP_W-1:0] alu_op,
	output logic      [`EXU_XLEN-1:0]     result,
	output logic                          alu_less,
	output logic                          alu_zero
);

	logic [`EXU_XLEN-1:0]    diff;
	logic                    carry;
	logic                    overflow;
	logic                    less_signed;
	logic                    less_unsigned;
	logic [`EXU_SHAMT_W-1:0] shamt;

	// src1 - src2 as src1 + ~src2 + 1, carry out is the inverted borrow
	assign {carry, diff} = {1'b0, src1} + {1'b0, ~src2} + {{`EXU_XLEN{1'b0}}, 1'b1};

	// Overflow only when signs differ and the result sign flips from src1
	assign overflow = (src1[`EXU_XLEN-1] ^ src2[`EXU_XLEN-1]) &
		(diff[`EXU_XLEN-1] ^ src1[`EXU_XLEN-1]);

	// Signed less is sign xor overflow
	assign less_signed = diff[`EXU_XLEN-1] ^ overflow;
	// Unsigned less is a borrow
	assign less_unsigned = ~carry;

	assign shamt = src2[`EXU_SHAMT_W-1:0];

	always_comb begin
		case (alu_op)
			`ALU_OP_ADD:           result = src1 + src2;
			`ALU_OP_SUB:           result = diff;
			`ALU_OP_XOR:           result = src1 ^ src2;
			`ALU_OP_OR:            result = src1 | src2;
			`ALU_OP_AND:           result = src1 & src2;
			`ALU_OP_RIGHT_LOGIC:   result = src1 >> shamt;
			`ALU_OP_RIGHT_ARITH:   result = $signed(src1) >>> shamt;
			`ALU_OP_LEFT_LOGIC:    result = src1 << shamt;
			`ALU_OP_LESS_SIGNED:   result = {{(`EXU_XLEN-1){1'b0}}, less_signed};
			`ALU_OP_LESS_UNSIGNED: result = {{(`EXU_XLEN-1){1'b0}}, less_unsigned};
			default:               result = '0;
		endcase
	end

	// Zero always from the difference, so eq/ne work with SUB
	assign alu_zero = (diff == '0);

	// Compare ops give their own flag, anything else the result sign
	always_comb begin
		case (alu_op)
			`ALU_OP_LESS_SIGNED:   alu_less = less_signed;
			`ALU_OP_LESS_UNSIGNED: alu_less = less_unsigned;
			default:               alu_less = result[`EXU_XLEN-1];
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/exu_branch_unit.sv
// Branch unit: evaluates the condition from ALU flags and forms the next pc
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_branch_unit (
	input  wire logic [`EXU_XLEN-1:0] pc,
	input  wire logic [`EXU_XLEN-1:0] imm,
	input  wire logic [2:0]           funct3,
	input  wire logic                 is_branch,
	input  wire logic                 alu_less,
	input  wire logic                 alu_zero,
	output logic      [`EXU_XLEN-1:0] next_pc,
	output logic                      branch_taken
);

	logic cond;

	// ALU already ran signed or unsigned compare per funct3
	always_comb begin
		case (funct3)
			3'b000:  cond = alu_zero;   // beq
			3'b001:  cond = ~alu_zero;  // bne
			3'b100:  cond = alu_less;   // blt
			3'b101:  cond = ~alu_less;  // bge
			3'b110:  cond = alu_less;   // bltu
			3'b111:  cond = ~alu_less;  // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = is_branch & cond;

	// Taken target or fall through
	always_comb begin
		if (branch_taken) begin
			next_pc = pc + imm;
		end else begin
			next_pc = pc + `EXU_XLEN'd4;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exu_ctrl.sv
// Execute control: decodes the instruction, drives datapath selects and holds the output stage
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_ctrl (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         in_valid,
	output logic                              in_ready,
	input  wire exu_pkg::inst_u               inst,
	input  wire logic     [`EXU_XLEN-1:0]     pc,
	input  wire logic     [`EXU_XLEN-1:0]     rs1_data,
	output logic          [`EXU_ALU_OP_W-1:0] alu_op,
	output exu_pkg::imm_sel_t                 imm_sel,
	output logic                              is_branch,
	output logic          [2:0]               funct3,
	output logic          [`EXU_XLEN-1:0]     src1,
	input  wire logic     [`EXU_XLEN-1:0]     alu_result,
	input  wire logic     [`EXU_XLEN-1:0]     next_pc_in,
	input  wire logic                         taken_in,
	output logic                              out_valid,
	input  wire logic                         out_ready,
	output logic          [4:0]               rd_addr,
	output logic          [`EXU_XLEN-1:0]     rd_data,
	output logic                              rd_write,
	output logic          [`EXU_XLEN-1:0]     next_pc,
	output logic                              branch_taken,
	output logic                              illegal
);

	import exu_pkg::*;

	src1_sel_t src1_sel;
	logic      writes_rd;
	logic      dec_illegal;
	logic      accept;

	// funct3 to ALU op, alt is funct7 bit 30 where it counts
	function automatic logic [`EXU_ALU_OP_W-1:0] alu_decode(input logic [2:0] f3,
		input logic alt);
		case (f3)
			3'b000:  alu_decode = alt ? `ALU_OP_SUB : `ALU_OP_ADD;
			3'b001:  alu_decode = `ALU_OP_LEFT_LOGIC;
			3'b010:  alu_decode = `ALU_OP_LESS_SIGNED;
			3'b011:  alu_decode = `ALU_OP_LESS_UNSIGNED;
			3'b100:  alu_decode = `ALU_OP_XOR;
			3'b101:  alu_decode = alt ? `ALU_OP_RIGHT_ARITH : `ALU_OP_RIGHT_LOGIC;
			3'b110:  alu_decode = `ALU_OP_OR;
			default: alu_decode = `ALU_OP_AND;
		endcase
	endfunction

	assign funct3 = inst.r.funct3;

	always_comb begin
		alu_op      = `ALU_OP_ADD;
		imm_sel     = IMM_NONE;
		src1_sel    = SRC1_RS1;
		is_branch   = 1'b0;
		writes_rd   = 1'b0;
		dec_illegal = 1'b0;
		case (inst.r.opcode)
			`OPC_OP: begin
				alu_op    = alu_decode(funct3, inst.r.funct7[5]);
				writes_rd = 1'b1;
			end
			`OPC_OP_IMM: begin
				// No subi, bit 30 only picks srai
				alu_op    = alu_decode(funct3, (funct3 == 3'b101) & inst.r.funct7[5]);
				imm_sel   = IMM_I;
				writes_rd = 1'b1;
			end
			`OPC_BRANCH: begin
				// eq/ne from zero flag, the rest from the compare
				if (funct3[2:1] == 2'b11) begin
					alu_op = `ALU_OP_LESS_UNSIGNED;
				end else if (funct3[2]) begin
					alu_op = `ALU_OP_LESS_SIGNED;
				end else begin
					alu_op = `ALU_OP_SUB;
				end
				imm_sel   = IMM_B;
				is_branch = 1'b1;
			end
			`OPC_LUI: begin
				imm_sel   = IMM_U;
				src1_sel  = SRC1_ZERO;
				writes_rd = 1'b1;
			end
			`OPC_AUIPC: begin
				imm_sel   = IMM_U;
				src1_sel  = SRC1_PC;
				writes_rd = 1'b1;
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	// First operand mux
	always_comb begin
		case (src1_sel)
			SRC1_PC:   src1 = pc;
			SRC1_ZERO: src1 = '0;
			default:   src1 = rs1_data;
		endcase
	end

	// Single entry, refills in the same cycle it drains
	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	// Control flags
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			rd_write     <= 1'b0;
			branch_taken <= 1'b0;
			illegal      <= 1'b0;
		end else if (accept) begin
			out_valid    <= 1'b1;
			rd_write     <= writes_rd & (inst.r.rd != 5'd0);
			branch_taken <= taken_in;
			illegal      <= dec_illegal;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (accept) begin
			rd_addr <= inst.r.rd;
			rd_data <= alu_result;
			next_pc <= next_pc_in;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exu_defines.svh
// Execute stage constants: data widths, ALU operation codes and RV32I opcodes
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Datapath widths
`define EXU_XLEN             32
`define EXU_SHAMT_W          5
`define EXU_ALU_OP_W         4

// ALU operation codes
`define ALU_OP_ADD           4'd0
`define ALU_OP_SUB           4'd1
`define ALU_OP_XOR           4'd2
`define ALU_OP_OR            4'd3
`define ALU_OP_AND           4'd4
`define ALU_OP_RIGHT_LOGIC   4'd5
`define ALU_OP_RIGHT_ARITH   4'd6
`define ALU_OP_LEFT_LOGIC    4'd7
`define ALU_OP_LESS_SIGNED   4'd8
`define ALU_OP_LESS_UNSIGNED 4'd9

// Major opcodes handled by the stage
`define OPC_OP               7'b0110011
`define OPC_OP_IMM           7'b0010011
`define OPC_BRANCH           7'b1100011
`define OPC_LUI              7'b0110111
`define OPC_AUIPC            7'b0010111

`endif

//--- verilog/exu_imm_gen.sv
// Immediate generator: sign-extends the I, B and U immediates and picks the second ALU operand
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_imm_gen (
	input  wire exu_pkg::inst_u              inst,
	input  wire exu_pkg::imm_sel_t           imm_sel,
	input  wire logic      [`EXU_XLEN-1:0]   rs2_data,
	output logic           [`EXU_XLEN-1:0]   imm,
	output logic           [`EXU_XLEN-1:0]   src2
);

	import exu_pkg::*;

	logic [`EXU_XLEN-1:0] imm_i;
	logic [`EXU_XLEN-1:0] imm_b;
	logic [`EXU_XLEN-1:0] imm_u;

	// I format, 12 bits sign-extended
	assign imm_i = {{(`EXU_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

	// B format, reassembled with an implicit zero LSB
	assign imm_b = {{(`EXU_XLEN-12){inst.b.imm12}},
		inst.b.imm11,
		inst.b.imm10_5,
		inst.b.imm4_1,
		1'b0};

	// U format in the upper 20 bits
	assign imm_u = {inst.u.imm20, 12'b0};

	always_comb begin
		case (imm_sel)
			IMM_I:   imm = imm_i;
			IMM_B:   imm = imm_b;
			IMM_U:   imm = imm_u;
			default: imm = '0;
		endcase
	end

	// Branches compare rs1 against rs2, the offset only goes to the branch unit
	always_comb begin
		if (imm_sel == IMM_NONE || imm_sel == IMM_B) begin
			src2 = rs2_data;
		end else begin
			src2 = imm;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
// Execute stage types: instruction format views and operand select encodings
`default_nettype none

package exu_pkg;

	// Register-register format
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// Immediate and shift-immediate format
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// Branch format, immediate bits scattered around the register fields
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// Upper-immediate format
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// One instruction word, four ways to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
	} inst_u;

	// Second operand source, IMM_NONE means rs2
	typedef enum logic [1:0] {
		IMM_I    = 2'd0,
		IMM_B    = 2'd1,
		IMM_U    = 2'd2,
		IMM_NONE = 2'd3
	} imm_sel_t;

	// First operand source
	typedef enum logic [1:0] {
		SRC1_RS1  = 2'd0,
		SRC1_PC   = 2'd1,
		SRC1_ZERO = 2'd2
	} src1_sel_t;

endpackage

`default_nettype wire

//--- verilog/exu_top.sv
// Execute stage top: control, immediate generator, ALU and branch unit
`include "exu_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_top (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 in_valid,
	output logic                      in_ready,
	input  wire exu_pkg::inst_u       inst,
	input  wire logic [`EXU_XLEN-1:0] pc,
	input  wire logic [`EXU_XLEN-1:0] rs1_data,
	input  wire logic [`EXU_XLEN-1:0] rs2_data,
	output logic                      out_valid,
	input  wire logic                 out_ready,
	output logic      [4:0]           rd_addr,
	output logic      [`EXU_XLEN-1:0] rd_data,
	output logic                      rd_write,
	output logic      [`EXU_XLEN-1:0] next_pc,
	output logic                      branch_taken,
	output logic                      illegal
);

	import exu_pkg::*;

	// Decode to datapath
	logic [`EXU_ALU_OP_W-1:0] alu_op;
	imm_sel_t                 imm_sel;
	logic                     is_branch;
	logic [2:0]               funct3;
	logic [`EXU_XLEN-1:0]     src1;

	// Datapath back to control
	logic [`EXU_XLEN-1:0]     imm;
	logic [`EXU_XLEN-1:0]     src2;
	logic [`EXU_XLEN-1:0]     alu_result;
	logic                     alu_less;
	logic                     alu_zero;
	logic [`EXU_XLEN-1:0]     pc_next;
	logic                     taken;

	exu_ctrl exu_ctrl_inst (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.inst         (inst),
		.pc           (pc),
		.rs1_data     (rs1_data),
		.alu_op       (alu_op),
		.imm_sel      (imm_sel),
		.is_branch    (is_branch),
		.funct3       (funct3),
		.src1         (src1),
		.alu_result   (alu_result),
		.next_pc_in   (pc_next),
		.taken_in     (taken),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.rd_write     (rd_write),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

	exu_imm_gen exu_imm_gen_inst (
		.inst     (inst),
		.imm_sel  (imm_sel),
		.rs2_data (rs2_data),
		.imm      (imm),
		.src2     (src2)
	);

	exu_alu exu_alu_inst (
		.src1     (src1),
		.src2     (src2),
		.alu_op   (alu_op),
		.result   (alu_result),
		.alu_less (alu_less),
		.alu_zero (alu_zero)
	);

	exu_branch_unit exu_branch_unit_inst (
		.pc           (pc),
		.imm          (imm),
		.funct3       (funct3),
		.is_branch    (is_branch),
		.alu_less     (alu_less),
		.alu_zero     (alu_zero),
		.next_pc      (pc_next),
		.branch_taken (taken)
	);

endmodule

`default_nettype wire
